//--- Makefile
VERILATOR := verilator
TOP       := tb_motion_sse
FILE_LIST := list.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The log is searched for the fail message; a crashed or stopped run also fails
run: compile
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Simulation run did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/sse_pkg.sv
// Defaults only. Every stage takes PIXEL_WIDTH and BLOCK_SIZE as parameters from the top level
package sse_pkg;

    // --------------------
    // Default geometry
    // --------------------

    // Bits per pixel, unsigned samples
    parameter int DEF_PIXEL_WIDTH = 8;

    // Block edge, also the lane count and row count. Must be a power of two
    parameter int DEF_BLOCK_SIZE = 16;

    // --------------------
    // Shared types
    // --------------------

    // SSE of a whole block, or the sum of one row
    typedef logic [31:0] sse_t;

    // Candidate number within one search
    typedef logic [7:0] cand_idx_t;

    // Row issue machine
    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

//--- list.f
common/sse_pkg.sv
sse/square_rom.sv
sse/row_sequencer.sv
sse/square_diff_stage.sv
sse/row_sum_stage.sv
sse/block_accumulator.sv
source/best_match_select.sv
source/motion_sse_top.sv
test/sse_props.sv
test/sse_checker.sv
test/tb_motion_sse.sv

//--- source/best_match_select.sv
// search_start wins over a done in the same cycle; that candidate is not counted
`timescale 1ns/1ns

module best_match_select (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               search_start,
    input  sse_pkg::sse_t      sse,
    input  logic               done,
    output sse_pkg::sse_t      best_sse,
    output sse_pkg::cand_idx_t best_index,
    output logic               best_valid
);
    import sse_pkg::*;

    cand_idx_t cand_cnt;
    logic      take;

    // Strictly smaller only, so ties keep the earlier candidate
    assign take = done && (!best_valid || (sse < best_sse));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_cnt   <= '0;
            best_sse   <= '0;
            best_index <= '0;
            best_valid <= 1'b0;
        end else if (search_start) begin
            cand_cnt   <= '0;
            best_sse   <= '0;
            best_index <= '0;
            best_valid <= 1'b0;
        end else begin
            if (done) begin
                cand_cnt <= cand_cnt + 1'b1;
            end
            if (take) begin
                best_sse   <= sse;
                best_index <= cand_cnt;
                best_valid <= 1'b1;
            end
        end
    end

endmodule

//--- source/motion_sse_top.sv
// done follows an accepted start by BLOCK_SIZE+4 cycles; no back-pressure on any output
`timescale 1ns/1ns

module motion_sse_top #(
    parameter int PIXEL_WIDTH = sse_pkg::DEF_PIXEL_WIDTH,
    parameter int BLOCK_SIZE  = sse_pkg::DEF_BLOCK_SIZE
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        start,
    input  logic                                        search_start,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE*BLOCK_SIZE-1:0] cur_block,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE*BLOCK_SIZE-1:0] ref_block,
    output sse_pkg::sse_t                               sse,
    output logic                                        done,
    output sse_pkg::sse_t                               best_sse,
    output sse_pkg::cand_idx_t                          best_index,
    output logic                                        best_valid
);
    import sse_pkg::*;

    logic                                row_valid;
    logic                                row_last;
    logic [PIXEL_WIDTH*BLOCK_SIZE-1:0]   cur_row;
    logic [PIXEL_WIDTH*BLOCK_SIZE-1:0]   ref_row;
    logic                                sq_valid;
    logic                                sq_last;
    logic [2*PIXEL_WIDTH*BLOCK_SIZE-1:0] sq_lanes;
    logic                                sum_valid;
    logic                                sum_last;
    sse_t                                row_sum;

    row_sequencer #(.PIXEL_WIDTH(PIXEL_WIDTH), .BLOCK_SIZE(BLOCK_SIZE)) u_row_sequencer (
        .clk, .rst_n, .start, .cur_block, .ref_block,
        .row_valid, .row_last, .cur_row, .ref_row
    );

    square_diff_stage #(.PIXEL_WIDTH(PIXEL_WIDTH), .BLOCK_SIZE(BLOCK_SIZE)) u_square_diff (
        .clk, .rst_n, .row_valid, .row_last, .cur_row, .ref_row,
        .sq_valid, .sq_last, .sq_lanes
    );

    row_sum_stage #(.PIXEL_WIDTH(PIXEL_WIDTH), .BLOCK_SIZE(BLOCK_SIZE)) u_row_sum (
        .clk, .rst_n, .sq_valid, .sq_last, .sq_lanes,
        .sum_valid, .sum_last, .row_sum
    );

    block_accumulator u_block_accumulator (
        .clk, .rst_n, .sum_valid, .sum_last, .row_sum, .sse, .done
    );

    // Selector watches the final SSE and its done pulse
    best_match_select u_best_match_select (
        .clk, .rst_n, .search_start, .sse, .done,
        .best_sse, .best_index, .best_valid
    );

endmodule

//--- sse/block_accumulator.sv
// Row sums of one block must arrive with sum_last on the final row; sse holds until the next done
`timescale 1ns/1ns

module block_accumulator (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sum_valid,
    input  logic          sum_last,
    input  sse_pkg::sse_t row_sum,
    output sse_pkg::sse_t sse,
    output logic          done
);
    import sse_pkg::*;

    sse_t acc;
    logic first_row;
    logic last_q;

    // --------------------
    // Running total
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            first_row <= 1'b1;
            last_q    <= 1'b0;
        end else begin
            last_q <= sum_valid & sum_last;
            if (sum_valid) begin
                acc       <= (first_row ? '0 : acc) + row_sum;
                first_row <= sum_last;
            end
        end
    end

    // --------------------
    // Result register
    // --------------------

    // acc may already take the next block's first row in this same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sse  <= '0;
            done <= 1'b0;
        end else begin
            done <= last_q;
            if (last_q) begin
                sse <= acc;
            end
        end
    end

endmodule

//--- sse/row_sequencer.sv
// A start is taken when idle or in the final issued row; starts at other times are dropped
`timescale 1ns/1ns

module row_sequencer #(
    parameter int PIXEL_WIDTH = sse_pkg::DEF_PIXEL_WIDTH,
    parameter int BLOCK_SIZE  = sse_pkg::DEF_BLOCK_SIZE
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        start,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE*BLOCK_SIZE-1:0] cur_block,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE*BLOCK_SIZE-1:0] ref_block,
    output logic                                        row_valid,
    output logic                                        row_last,
    output logic [PIXEL_WIDTH*BLOCK_SIZE-1:0]           cur_row,
    output logic [PIXEL_WIDTH*BLOCK_SIZE-1:0]           ref_row
);
    import sse_pkg::*;

    localparam int ROW_W   = PIXEL_WIDTH * BLOCK_SIZE;
    localparam int BLOCK_W = ROW_W * BLOCK_SIZE;
    localparam int CNT_W   = $clog2(BLOCK_SIZE);

    seq_state_t         state;
    logic [CNT_W-1:0]   row_cnt;
    logic [BLOCK_W-1:0] cur_q;
    logic [BLOCK_W-1:0] ref_q;
    logic               accept;

    // Final row frees the sequencer, so starts can be spaced BLOCK_SIZE apart
    assign row_last  = (state == SEQ_ISSUE) && (row_cnt == CNT_W'(BLOCK_SIZE - 1));
    assign accept    = start && ((state == SEQ_IDLE) || row_last);
    assign row_valid = (state == SEQ_ISSUE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SEQ_IDLE;
            row_cnt <= '0;
            cur_q   <= '0;
            ref_q   <= '0;
        end else if (accept) begin
            state   <= SEQ_ISSUE;
            row_cnt <= '0;
            cur_q   <= cur_block;
            ref_q   <= ref_block;
        end else if (row_last) begin
            state   <= SEQ_IDLE;
            row_cnt <= '0;
        end else if (state == SEQ_ISSUE) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // Row 0 sits in the low bits of the block
    assign cur_row = cur_q[row_cnt*ROW_W +: ROW_W];
    assign ref_row = ref_q[row_cnt*ROW_W +: ROW_W];

endmodule

//--- sse/row_sum_stage.sv
// BLOCK_SIZE must be a power of two for the heap-ordered adder tree
`timescale 1ns/1ns

module row_sum_stage #(
    parameter int PIXEL_WIDTH = sse_pkg::DEF_PIXEL_WIDTH,
    parameter int BLOCK_SIZE  = sse_pkg::DEF_BLOCK_SIZE
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                sq_valid,
    input  logic                                sq_last,
    input  logic [2*PIXEL_WIDTH*BLOCK_SIZE-1:0] sq_lanes,
    output logic                                sum_valid,
    output logic                                sum_last,
    output sse_pkg::sse_t                       row_sum
);
    import sse_pkg::*;

    localparam int SQ_W = 2 * PIXEL_WIDTH;

    // Node k has children 2k and 2k+1, leaves sit at BLOCK_SIZE and up
    sse_t tree [1:2*BLOCK_SIZE-1];

    always_comb begin
        for (int k = 0; k < BLOCK_SIZE; k++) begin
            tree[BLOCK_SIZE+k] = sse_t'(sq_lanes[k*SQ_W +: SQ_W]);
        end
        for (int k = BLOCK_SIZE - 1; k >= 1; k--) begin
            tree[k] = tree[2*k] + tree[2*k+1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
            sum_last  <= 1'b0;
            row_sum   <= '0;
        end else begin
            sum_valid <= sq_valid;
            sum_last  <= sq_last & sq_valid;
            row_sum   <= tree[1];
        end
    end

endmodule

//--- sse/square_diff_stage.sv
// Two cycle latency from row to squares; pixels are unsigned, differences are signed
`timescale 1ns/1ns

module square_diff_stage #(
    parameter int PIXEL_WIDTH = sse_pkg::DEF_PIXEL_WIDTH,
    parameter int BLOCK_SIZE  = sse_pkg::DEF_BLOCK_SIZE
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                row_valid,
    input  logic                                row_last,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE-1:0]   cur_row,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE-1:0]   ref_row,
    output logic                                sq_valid,
    output logic                                sq_last,
    output logic [2*PIXEL_WIDTH*BLOCK_SIZE-1:0] sq_lanes
);

    localparam int SQ_W = 2 * PIXEL_WIDTH;

    logic valid_d1;
    logic last_d1;

    // Strobes follow the difference register, then the ROM read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
            last_d1  <= 1'b0;
            sq_valid <= 1'b0;
            sq_last  <= 1'b0;
        end else begin
            valid_d1 <= row_valid;
            last_d1  <= row_last & row_valid;
            sq_valid <= valid_d1;
            sq_last  <= last_d1;
        end
    end

    for (genvar g = 0; g < BLOCK_SIZE; g++) begin : g_lane
        logic signed [PIXEL_WIDTH:0] diff_q;

        // One extra bit holds the sign of the difference
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                diff_q <= '0;
            end else begin
                diff_q <= $signed({1'b0, cur_row[g*PIXEL_WIDTH +: PIXEL_WIDTH]})
                        - $signed({1'b0, ref_row[g*PIXEL_WIDTH +: PIXEL_WIDTH]});
            end
        end

        square_rom #(
            .PIXEL_WIDTH (PIXEL_WIDTH)
        ) u_square_rom (
            .clk    (clk),
            .diff   (diff_q),
            .square (sq_lanes[g*SQ_W +: SQ_W])
        );
    end

endmodule

//--- sse/square_rom.sv
// Entry for the most negative difference wraps, but unsigned pixel pairs never reach it
`timescale 1ns/1ns

module square_rom #(
    parameter int PIXEL_WIDTH = sse_pkg::DEF_PIXEL_WIDTH
) (
    input  logic                          clk,
    input  logic signed [PIXEL_WIDTH:0]   diff,
    output logic [2*PIXEL_WIDTH-1:0]      square
);

    localparam int SQ_W  = 2 * PIXEL_WIDTH;
    localparam int DEPTH = 2 ** (PIXEL_WIDTH + 1);

    logic [SQ_W-1:0] rom_data [DEPTH];

    // Index is the two's complement pattern of the difference
    function automatic logic [SQ_W-1:0] square_of(input int unsigned idx);
        logic signed [PIXEL_WIDTH:0] d;
        longint                      sq;
        d  = idx[PIXEL_WIDTH:0];
        sq = longint'(d) * longint'(d);
        return sq[SQ_W-1:0];
    endfunction

    for (genvar g = 0; g < DEPTH; g++) begin : g_entry
        assign rom_data[g] = square_of(g);
    end

    always_ff @(posedge clk) begin
        square <= rom_data[$unsigned(diff)];
    end

endmodule

//--- test/sse_checker.sv
// Samples on the rising edge; expects unsigned pixels and the drop rule for starts during issue
`timescale 1ns/1ns

module sse_checker #(
    parameter int PIXEL_WIDTH = sse_pkg::DEF_PIXEL_WIDTH,
    parameter int BLOCK_SIZE  = sse_pkg::DEF_BLOCK_SIZE
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        start,
    input  logic                                        search_start,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE*BLOCK_SIZE-1:0] cur_block,
    input  logic [PIXEL_WIDTH*BLOCK_SIZE*BLOCK_SIZE-1:0] ref_block,
    input  sse_pkg::sse_t                               sse,
    input  logic                                        done,
    input  sse_pkg::sse_t                               best_sse,
    input  sse_pkg::cand_idx_t                          best_index,
    input  logic                                        best_valid,
    output int                                          value_errs,
    output int                                          other_errs,
    output int                                          pending
);
    import sse_pkg::*;

    localparam int BLOCK_W = PIXEL_WIDTH * BLOCK_SIZE * BLOCK_SIZE;
    localparam int NPIX    = BLOCK_SIZE * BLOCK_SIZE;
    // done rises BLOCK_SIZE+4 edges after start and is seen one edge later
    localparam int SEEN_AT = BLOCK_SIZE + 5;

    sse_t      exp_sse_q [$];
    longint    exp_edge_q [$];
    longint    edge_no      = 0;
    int        issue_left   = 0;
    int        n_value      = 0;
    int        n_other      = 0;
    int        n_pending    = 0;
    cand_idx_t m_cnt        = '0;
    sse_t      m_best_sse   = '0;
    cand_idx_t m_best_idx   = '0;
    logic      m_best_valid = 1'b0;

    assign value_errs = n_value;
    assign other_errs = n_other;
    assign pending    = n_pending;

    // Sum over all pixels of the squared difference
    function automatic sse_t block_sse(input logic [BLOCK_W-1:0] c, input logic [BLOCK_W-1:0] r);
        int   d;
        sse_t acc;
        acc = '0;
        for (int p = 0; p < NPIX; p++) begin
            d   = int'(c[p*PIXEL_WIDTH +: PIXEL_WIDTH]) - int'(r[p*PIXEL_WIDTH +: PIXEL_WIDTH]);
            acc = acc + sse_t'(d * d);
        end
        return acc;
    endfunction

    task automatic report_value(input string name, input longint expv, input longint gotv);
        n_value++;
        $display("[FAIL] %0t %s: expected %0d, got %0d", $time, name, expv, gotv);
    endtask

    task automatic report_other(input string what);
        n_other++;
        $display("[ERROR] %0t %s", $time, what);
    endtask

    always @(posedge clk or negedge rst_n) begin
        sse_t   exp_v;
        longint exp_at;
        if (!rst_n) begin
            exp_sse_q.delete();
            exp_edge_q.delete();
            issue_left   = 0;
            m_cnt        = '0;
            m_best_sse   = '0;
            m_best_idx   = '0;
            m_best_valid = 1'b0;
            n_pending    = 0;
        end else begin
            edge_no = edge_no + 1;

            // Selector outputs against the model as it stood before this edge
            if (best_valid !== m_best_valid) begin
                report_value("best_valid", longint'(m_best_valid), longint'(best_valid));
            end else if (m_best_valid) begin
                if (best_sse !== m_best_sse)
                    report_value("best_sse", longint'(m_best_sse), longint'(best_sse));
                if (best_index !== m_best_idx)
                    report_value("best_index", longint'(m_best_idx), longint'(best_index));
            end

            // A result whose slot went by without done is lost
            while (exp_edge_q.size() > 0 && exp_edge_q[0] < edge_no) begin
                report_other("no done for an accepted start");
                void'(exp_sse_q.pop_front());
                void'(exp_edge_q.pop_front());
            end

            if (search_start) begin
                m_cnt        = '0;
                m_best_sse   = '0;
                m_best_idx   = '0;
                m_best_valid = 1'b0;
            end

            if (done) begin
                if (exp_sse_q.size() == 0) begin
                    report_other("done pulse with no accepted start waiting");
                end else begin
                    exp_v  = exp_sse_q.pop_front();
                    exp_at = exp_edge_q.pop_front();
                    if (exp_at != edge_no)
                        report_value("done edge", exp_at, edge_no);
                    if (sse !== exp_v)
                        report_value("sse", longint'(exp_v), longint'(sse));
                    // search_start in the same cycle drops this candidate
                    if (!search_start) begin
                        if (!m_best_valid || exp_v < m_best_sse) begin
                            m_best_sse   = exp_v;
                            m_best_idx   = m_cnt;
                            m_best_valid = 1'b1;
                        end
                        m_cnt = m_cnt + 8'd1;
                    end
                end
            end

            // Taken when idle or while the final row is out
            if (start && issue_left <= 1) begin
                exp_sse_q.push_back(block_sse(cur_block, ref_block));
                exp_edge_q.push_back(edge_no + SEEN_AT);
                issue_left = BLOCK_SIZE;
            end else if (issue_left > 0) begin
                issue_left = issue_left - 1;
            end

            n_pending = exp_sse_q.size();
        end
    end

endmodule

//--- test/sse_props.sv
// Bound into motion_sse_top; the row count check assumes one block in row issue at a time
`timescale 1ns/1ns

module sse_props #(
    parameter int BLOCK_SIZE = sse_pkg::DEF_BLOCK_SIZE
) (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic row_valid,
    input logic row_last,
    input logic done,
    input logic best_valid
);

    localparam int CNT_W = $clog2(BLOCK_SIZE + 1);

    logic [CNT_W-1:0] rows_left;
    logic             accepted;

    // Count of failed properties
    int               fails = 0;

    // Start is taken with no row out, or with the final row out
    assign accepted = start && (!row_valid || row_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_left <= '0;
        end else if (accepted) begin
            rows_left <= CNT_W'(BLOCK_SIZE);
        end else if (rows_left != '0) begin
            rows_left <= rows_left - CNT_W'(1);
        end
    end

    // --------------------
    // Pulse and strobe rules
    // --------------------

    a_single_done: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fails++;
            $error("done stayed high for two cycles in a row");
        end

    a_row_count: assert property (@(posedge clk) disable iff (!rst_n)
        row_valid == (rows_left != '0))
        else begin
            fails++;
            $error("row_valid run differs from BLOCK_SIZE rows per accepted start");
        end

    a_quiet_reset: assert property (@(posedge clk) !rst_n |-> (!done && !best_valid))
        else begin
            fails++;
            $error("done or best_valid high during reset");
        end

    a_quiet_release: assert property (@(posedge clk) $rose(rst_n) |-> (!done && !best_valid))
        else begin
            fails++;
            $error("done or best_valid high right after reset release");
        end

endmodule

//--- test/tb_motion_sse.sv
// Default geometry only; the run is bounded by a watchdog sized from the number of starts
`timescale 1ns/1ns

module tb_motion_sse;
    import sse_pkg::*;

    localparam int PIXEL_WIDTH = DEF_PIXEL_WIDTH;
    localparam int BLOCK_SIZE  = DEF_BLOCK_SIZE;
    localparam int BLOCK_W     = PIXEL_WIDTH * BLOCK_SIZE * BLOCK_SIZE;
    localparam int CLK_NS      = 20;
    localparam int NUM_STARTS  = 32;
    localparam int TIMEOUT_NS  = (NUM_STARTS * (BLOCK_SIZE + 8) + 208) * CLK_NS;

    // Block pair flavors
    localparam int MODE_RANDOM  = 0;
    localparam int MODE_EXTREME = 1;
    localparam int MODE_SAME    = 2;
    localparam int MODE_NEAR    = 3;
    localparam int MODE_FULL    = 4;

    localparam logic [PIXEL_WIDTH-1:0] MAX_PIX = '1;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               start;
    logic               search_start;
    logic [BLOCK_W-1:0] cur_block;
    logic [BLOCK_W-1:0] ref_block;
    sse_t               sse;
    logic               done;
    sse_t               best_sse;
    cand_idx_t          best_index;
    logic               best_valid;
    int                 value_errs;
    int                 other_errs;
    int                 pending;
    int                 seed = 32'h79e2_c0f2;
    logic [BLOCK_W-1:0] pair_cur;
    logic [BLOCK_W-1:0] pair_ref;

    always #(CLK_NS / 2) clk = ~clk;

    motion_sse_top #(.PIXEL_WIDTH(PIXEL_WIDTH), .BLOCK_SIZE(BLOCK_SIZE)) dut_i (
        .clk, .rst_n, .start, .search_start, .cur_block, .ref_block,
        .sse, .done, .best_sse, .best_index, .best_valid
    );

    sse_checker #(.PIXEL_WIDTH(PIXEL_WIDTH), .BLOCK_SIZE(BLOCK_SIZE)) chk_i (
        .clk, .rst_n, .start, .search_start, .cur_block, .ref_block,
        .sse, .done, .best_sse, .best_index, .best_valid,
        .value_errs, .other_errs, .pending
    );

    bind motion_sse_top sse_props #(.BLOCK_SIZE(BLOCK_SIZE)) props_i (
        .clk, .rst_n, .start, .row_valid, .row_last, .done, .best_valid
    );

    // --------------------
    // Stimulus helpers
    // --------------------

    task automatic fill_pair(input int mode);
        logic [31:0] rnd;
        for (int p = 0; p < BLOCK_SIZE * BLOCK_SIZE; p++) begin
            rnd = $random(seed);
            case (mode)
                MODE_EXTREME: begin
                    pair_cur[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[0] ? MAX_PIX : '0;
                    pair_ref[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[1] ? MAX_PIX : '0;
                end
                MODE_FULL: begin
                    pair_cur[p*PIXEL_WIDTH +: PIXEL_WIDTH] = MAX_PIX;
                    pair_ref[p*PIXEL_WIDTH +: PIXEL_WIDTH] = '0;
                end
                MODE_SAME: begin
                    pair_cur[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[PIXEL_WIDTH-1:0];
                    pair_ref[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[PIXEL_WIDTH-1:0];
                end
                MODE_NEAR: begin
                    pair_cur[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[PIXEL_WIDTH-1:0];
                    pair_ref[p*PIXEL_WIDTH +: PIXEL_WIDTH] =
                        rnd[PIXEL_WIDTH-1:0] ^ PIXEL_WIDTH'(rnd[17:16]);
                end
                default: begin
                    pair_cur[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[PIXEL_WIDTH-1:0];
                    pair_ref[p*PIXEL_WIDTH +: PIXEL_WIDTH] = rnd[2*PIXEL_WIDTH-1:PIXEL_WIDTH];
                end
            endcase
        end
    endtask

    // Called on a rising edge; returns on the edge that samples start
    task automatic start_block();
        start     <= 1'b1;
        cur_block <= pair_cur;
        ref_block <= pair_ref;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic new_search();
        search_start <= 1'b1;
        @(posedge clk);
        search_start <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Wait until every accepted block has come back
    task automatic drain();
        do @(negedge clk); while (pending != 0);
        @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int gap;
        int skip;
        rst_n        = 1'b0;
        start        = 1'b0;
        search_start = 1'b0;
        cur_block    = '0;
        ref_block    = '0;
        pair_cur     = '0;
        pair_ref     = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Search of random candidates with uneven spacing
        new_search();
        for (int i = 0; i < 8; i++) begin
            gap = 15 + int'($unsigned($random(seed)) % 9);
            fill_pair(MODE_RANDOM);
            start_block();
            wait_cycles(gap);
        end
        drain();

        // Extreme pixel values
        for (int i = 0; i < 4; i++) begin
            fill_pair(i == 3 ? MODE_FULL : MODE_EXTREME);
            start_block();
            wait_cycles(17);
        end
        drain();

        // Back to back, several blocks in flight
        for (int i = 0; i < 6; i++) begin
            fill_pair(MODE_RANDOM);
            start_block();
            wait_cycles(BLOCK_SIZE - 1);
        end
        drain();

        // Second start lands inside row issue and is dropped
        for (int t = 0; t < 3; t++) begin
            fill_pair(MODE_RANDOM);
            start_block();
            skip = (t == 0) ? BLOCK_SIZE - 2 : int'($unsigned($random(seed)) % 14);
            wait_cycles(skip);
            fill_pair(MODE_RANDOM);
            start_block();
            drain();
        end

        // Identical pairs give zero, a repeat ties and the earlier index stays
        new_search();
        fill_pair(MODE_NEAR);
        start_block();
        wait_cycles(17);
        fill_pair(MODE_SAME);
        start_block();
        wait_cycles(17);
        start_block();
        wait_cycles(17);
        fill_pair(MODE_RANDOM);
        start_block();
        drain();

        // Numbering restarts at 0 after a fresh search
        new_search();
        for (int i = 0; i < 4; i++) begin
            fill_pair(i[0] ? MODE_NEAR : MODE_RANDOM);
            start_block();
            wait_cycles(17);
        end
        drain();

        wait_cycles(4);
        @(negedge clk);
        $display("Errors: %0d value, %0d other, %0d assertion, %0d results outstanding",
                 value_errs, other_errs, dut_i.props_i.fails, pending);
        if (pending != 0)
            $display("Some accepted blocks never produced a done pulse");
        if (value_errs == 0 && other_errs == 0 && dut_i.props_i.fails == 0 && pending == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
